// ==== files.f ====
+incdir+.
adder_pkg.sv
adder_core.sv
axil_slave.sv
adder_top.sv
adder_properties.sv
adder_checker.sv
adder_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module adder_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vadder_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1

// ==== adder_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adder_cfg.svh"

module adder_tb;

   localparam adder_pkg::addr_t OFS_A     = adder_pkg::addr_t'(`ADDER_OFS_A);
   localparam adder_pkg::addr_t OFS_B     = adder_pkg::addr_t'(`ADDER_OFS_B);
   localparam adder_pkg::addr_t OFS_SUM   = adder_pkg::addr_t'(`ADDER_OFS_SUM);
   localparam adder_pkg::addr_t OFS_CARRY = adder_pkg::addr_t'(`ADDER_OFS_CARRY);
   localparam int N_FULL  = 6;
   localparam int N_PART  = 6;
   localparam int N_BAD   = 6;
   localparam int N_STALL = 8;
   localparam int NUM_TESTS = 6;
   localparam int NUM_TXN = 4 + N_FULL*6 + N_PART*3 + 16 + N_BAD*2 + 4 + N_STALL*2;

   logic             s1_axi_aclk;
   logic             rst_n;
   adder_pkg::addr_t awaddr;
   logic             awvalid;
   logic             awready;
   adder_pkg::data_t wdata;
   adder_pkg::strb_t wstrb;
   logic             wvalid;
   logic             wready;
   adder_pkg::resp_t bresp;
   logic             bvalid;
   logic             bready;
   adder_pkg::addr_t araddr;
   logic             arvalid;
   logic             arready;
   adder_pkg::data_t rdata;
   adder_pkg::resp_t rresp;
   logic             rvalid;
   logic             rready;
   int               test_num;
   int               error_count;
   int               open_resp;
   int               errs_before;
   int               failed_tests;
   int               stall_bits;
   logic [31:0]      lfsr_state;

   adder_top u_adder_top (.*);
   adder_checker u_checker (.*);
   bind adder_top adder_properties u_properties (.*);

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      end
      return val;
   endfunction

   task automatic write_reg(input adder_pkg::addr_t addr, input adder_pkg::data_t data,
                            input adder_pkg::strb_t strb);
      int stall;
      stall = int'(lfsr_bits(stall_bits));
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      @(negedge s1_axi_aclk);
      while (!awready)
         @(negedge s1_axi_aclk);
      @(negedge s1_axi_aclk);
      awvalid = 1'b0;
      wvalid = 1'b0;
      repeat (stall) @(negedge s1_axi_aclk);
      bready = 1'b1;
      while (!bvalid)
         @(negedge s1_axi_aclk);
      @(negedge s1_axi_aclk);
      bready = 1'b0;
   endtask

   task automatic read_reg(input adder_pkg::addr_t addr);
      int stall;
      stall = int'(lfsr_bits(stall_bits));
      araddr = addr;
      arvalid = 1'b1;
      @(negedge s1_axi_aclk);
      while (!arready)
         @(negedge s1_axi_aclk);
      @(negedge s1_axi_aclk);
      arvalid = 1'b0;
      repeat (stall) @(negedge s1_axi_aclk);
      rready = 1'b1;
      while (!rvalid)
         @(negedge s1_axi_aclk);
      @(negedge s1_axi_aclk);
      rready = 1'b0;
   endtask

   task automatic read_all();
      read_reg(OFS_A);
      read_reg(OFS_B);
      read_reg(OFS_SUM);
      read_reg(OFS_CARRY);
   endtask

   task automatic overflow_pair(input adder_pkg::data_t a, input adder_pkg::data_t b);
      write_reg(OFS_A, a, 4'hf);
      write_reg(OFS_B, b, 4'hf);
      read_reg(OFS_SUM);
      read_reg(OFS_CARRY);
   endtask

   task automatic start_test(input int n);
      test_num = n;
      errs_before = error_count;
   endtask

   task automatic finish_test();
      if (error_count == errs_before)
         $display("%s: ok", u_checker.test_name(test_num));
      else
      begin
         $display("%s: %0d errors", u_checker.test_name(test_num), error_count - errs_before);
         failed_tests++;
      end
   endtask

   initial
   begin
      s1_axi_aclk = 1'b0;
      forever #5 s1_axi_aclk = ~s1_axi_aclk;
   end

   // Watchdog sized from the transaction count
   initial
   begin
      #(NUM_TXN * 20 * 10);
      $display("Timeout: the run did not finish within %0d ns", NUM_TXN * 20 * 10);
      $display("test failed");
      $finish;
   end

   initial
   begin
      adder_pkg::data_t opa;
      adder_pkg::addr_t bad;
      lfsr_state = 32'h8de4;
      rst_n = 1'b0;
      {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
      {araddr, arvalid, rready} = '0;
      test_num = 0;
      failed_tests = 0;
      stall_bits = 3;
      repeat (3) @(posedge s1_axi_aclk);
      @(negedge s1_axi_aclk);
      rst_n = 1'b1;

      start_test(0);
      read_all();
      finish_test();

      start_test(1);
      repeat (N_FULL)
      begin
         write_reg(OFS_A, lfsr_bits(32), 4'hf);
         write_reg(OFS_B, lfsr_bits(32), 4'hf);
         read_all();
      end
      finish_test();

      start_test(2);
      repeat (N_PART)
      begin
         bad = lfsr_bits(1) != 0 ? OFS_B : OFS_A;
         opa = lfsr_bits(32);
         write_reg(bad, opa, adder_pkg::strb_t'(lfsr_bits(4)));
         read_reg(OFS_A);
         read_reg(OFS_B);
      end
      finish_test();

      start_test(3);
      overflow_pair(32'hffff_ffff, 32'h0000_0001);
      overflow_pair(32'h8000_0000, 32'h8000_0000);
      overflow_pair(32'hffff_ffff, 32'hffff_ffff);
      opa = lfsr_bits(32) | 32'h8000_0000;
      overflow_pair(opa, lfsr_bits(32) | 32'h8000_0000);
      finish_test();

      // Odd addresses are never mapped
      start_test(4);
      for (int i = 0; i < N_BAD; i++)
      begin
         bad = (i % 3 == 0) ? OFS_SUM : (i % 3 == 1) ? OFS_CARRY :
               (adder_pkg::addr_t'(lfsr_bits(8)) | 8'h01);
         write_reg(bad, lfsr_bits(32), 4'hf);
         read_reg(adder_pkg::addr_t'(lfsr_bits(8)) | 8'h01);
      end
      read_all();
      finish_test();

      start_test(5);
      stall_bits = 4;
      repeat (N_STALL)
      begin
         bad = lfsr_bits(1) != 0 ? OFS_B : OFS_A;
         write_reg(bad, lfsr_bits(32), 4'hf);
         read_reg(adder_pkg::addr_t'(lfsr_bits(2) * 4));
      end
      finish_test();

      repeat (4) @(negedge s1_axi_aclk);
      if (open_resp != 0)
      begin
         $display("%0d accepted addresses never got a response", open_resp);
         failed_tests++;
      end
      $display("Tests run: %0d, failing tests: %0d, errors: %0d",
               NUM_TESTS, failed_tests, error_count);
      if (failed_tests == 0 && error_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== adder_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adder_cfg.svh"

module adder_checker
(
   input  wire logic             s1_axi_aclk,
   input  wire logic             rst_n,
   input  wire adder_pkg::addr_t awaddr,
   input  wire logic             awvalid,
   input  wire logic             awready,
   input  wire adder_pkg::data_t wdata,
   input  wire adder_pkg::strb_t wstrb,
   input  wire logic             wvalid,
   input  wire logic             wready,
   input  wire adder_pkg::resp_t bresp,
   input  wire logic             bvalid,
   input  wire logic             bready,
   input  wire adder_pkg::addr_t araddr,
   input  wire logic             arvalid,
   input  wire logic             arready,
   input  wire adder_pkg::data_t rdata,
   input  wire adder_pkg::resp_t rresp,
   input  wire logic             rvalid,
   input  wire logic             rready,
   input  wire logic [31:0]      test_num,
   output int                    error_count,
   output int                    open_resp
);

   localparam adder_pkg::addr_t OFS_A     = adder_pkg::addr_t'(`ADDER_OFS_A);
   localparam adder_pkg::addr_t OFS_B     = adder_pkg::addr_t'(`ADDER_OFS_B);
   localparam adder_pkg::addr_t OFS_SUM   = adder_pkg::addr_t'(`ADDER_OFS_SUM);
   localparam adder_pkg::addr_t OFS_CARRY = adder_pkg::addr_t'(`ADDER_OFS_CARRY);
   localparam adder_pkg::resp_t OKAY      = 2'd0;
   localparam adder_pkg::resp_t SLVERR    = 2'd2;

   adder_pkg::data_t model_a;
   adder_pkg::data_t model_b;
   adder_pkg::resp_t exp_bresp[$];
   adder_pkg::data_t exp_rdata[$];
   adder_pkg::resp_t exp_rresp[$];

   function automatic string test_name(input int n);
      case (n)
         0: return "reset_reads";
         1: return "full_strobe";
         2: return "partial_strobe";
         3: return "overflow";
         4: return "slverr";
         default: return "stalls";
      endcase
   endfunction

   function automatic adder_pkg::data_t strobe_merge(input adder_pkg::data_t old_word,
                                                     input adder_pkg::data_t new_word,
                                                     input adder_pkg::strb_t strb);
      adder_pkg::data_t mask;
      for (int i = 0; i < `ADDER_DATA_WIDTH/8; i++)
         mask[8*i +: 8] = {8{strb[i]}};
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   always @(posedge s1_axi_aclk)
   begin
      adder_pkg::resp_t exp_resp;
      adder_pkg::data_t exp_data;
      logic [32:0]      full_sum;
      if (!rst_n)
      begin
         model_a = '0;
         model_b = '0;
         exp_bresp.delete();
         exp_rdata.delete();
         exp_rresp.delete();
         error_count = 0;
         open_resp = 0;
      end
      else
      begin
         full_sum = {1'b0, model_a} + {1'b0, model_b};
         if (awvalid && awready && wvalid && wready)
         begin
            exp_resp = OKAY;
            if (awaddr == OFS_A)
               model_a = strobe_merge(model_a, wdata, wstrb);
            else if (awaddr == OFS_B)
               model_b = strobe_merge(model_b, wdata, wstrb);
            else
               exp_resp = SLVERR;
            exp_bresp.push_back(exp_resp);
            open_resp++;
         end
         if (bvalid && bready)
         begin
            if (exp_bresp.size() == 0)
            begin
               $display("Write response without an accepted write in %s", test_name(test_num));
               error_count++;
            end
            else
            begin
               exp_resp = exp_bresp.pop_front();
               open_resp--;
               if (bresp !== exp_resp)
               begin
                  $display("Mismatch in %s: bresp expected %0d actual %0d",
                           test_name(test_num), exp_resp, bresp);
                  error_count++;
               end
            end
         end
         if (arvalid && arready)
         begin
            exp_resp = OKAY;
            if (araddr == OFS_A)
               exp_data = model_a;
            else if (araddr == OFS_B)
               exp_data = model_b;
            else if (araddr == OFS_SUM)
               exp_data = full_sum[31:0];
            else if (araddr == OFS_CARRY)
               exp_data = {31'd0, full_sum[32]};
            else
            begin
               exp_data = '0;
               exp_resp = SLVERR;
            end
            exp_rdata.push_back(exp_data);
            exp_rresp.push_back(exp_resp);
            open_resp++;
         end
         if (rvalid && rready)
         begin
            if (exp_rdata.size() == 0)
            begin
               $display("Read response without an accepted read in %s", test_name(test_num));
               error_count++;
            end
            else
            begin
               exp_data = exp_rdata.pop_front();
               exp_resp = exp_rresp.pop_front();
               open_resp--;
               if (rdata !== exp_data || rresp !== exp_resp)
               begin
                  $display("Mismatch in %s: read expected %h/%0d actual %h/%0d",
                           test_name(test_num), exp_data, exp_resp, rdata, rresp);
                  error_count++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== adder_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module adder_properties
(
   input wire logic             s1_axi_aclk,
   input wire logic             rst_n,
   input wire adder_pkg::addr_t awaddr,
   input wire logic             awvalid,
   input wire logic             awready,
   input wire adder_pkg::data_t wdata,
   input wire adder_pkg::strb_t wstrb,
   input wire logic             wvalid,
   input wire logic             wready,
   input wire adder_pkg::resp_t bresp,
   input wire logic             bvalid,
   input wire logic             bready,
   input wire adder_pkg::addr_t araddr,
   input wire logic             arvalid,
   input wire logic             arready,
   input wire adder_pkg::data_t rdata,
   input wire adder_pkg::resp_t rresp,
   input wire logic             rvalid,
   input wire logic             rready
);

   // Valid and payload held until the beat transfers
   aw_hold: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr))
      else $error("awvalid or awaddr changed before the transfer");
   w_hold: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
      else $error("wvalid or write data changed before the transfer");
   b_hold: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid or bresp changed before the transfer");
   ar_hold: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("arvalid or araddr changed before the transfer");
   r_hold: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid or read data changed before the transfer");

   // Reset is synchronous, so outputs are low one edge later
   reset_quiet: assert property (@(posedge s1_axi_aclk)
      !rst_n |=> !awready && !wready && !arready && !bvalid && !rvalid)
      else $error("Handshake outputs active during reset");

   aw_w_ready: assert property (@(posedge s1_axi_aclk) disable iff (!rst_n)
      awready == wready)
      else $error("awready and wready differ");

endmodule

`default_nettype wire

// ==== adder_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module adder_top
(
   input  wire logic              s1_axi_aclk,
   input  wire logic              rst_n,

   input  wire adder_pkg::addr_t  awaddr,
   input  wire logic              awvalid,
   output logic                   awready,

   input  wire adder_pkg::data_t  wdata,
   input  wire adder_pkg::strb_t  wstrb,
   input  wire logic              wvalid,
   output logic                   wready,

   output adder_pkg::resp_t       bresp,
   output logic                   bvalid,
   input  wire logic              bready,

   input  wire adder_pkg::addr_t  araddr,
   input  wire logic              arvalid,
   output logic                   arready,

   output adder_pkg::data_t       rdata,
   output adder_pkg::resp_t       rresp,
   output logic                   rvalid,
   input  wire logic              rready
);

   logic             a_we;
   logic             b_we;
   adder_pkg::data_t wr_data;
   adder_pkg::strb_t wr_strb;
   adder_pkg::data_t operand_a;
   adder_pkg::data_t operand_b;
   adder_pkg::data_t sum;
   logic             carry;

   axil_slave u_axil_slave
   (
      .s1_axi_aclk (s1_axi_aclk),
      .rst_n       (rst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .a_we        (a_we),
      .b_we        (b_we),
      .wr_data     (wr_data),
      .wr_strb     (wr_strb),
      .operand_a   (operand_a),
      .operand_b   (operand_b),
      .sum         (sum),
      .carry       (carry)
   );

   adder_core u_adder_core
   (
      .s1_axi_aclk (s1_axi_aclk),
      .rst_n       (rst_n),
      .a_we        (a_we),
      .b_we        (b_we),
      .wr_data     (wr_data),
      .wr_strb     (wr_strb),
      .operand_a   (operand_a),
      .operand_b   (operand_b),
      .sum         (sum),
      .carry       (carry)
   );

endmodule

`default_nettype wire

// ==== axil_slave.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adder_cfg.svh"

module axil_slave
(
   input  wire logic              s1_axi_aclk,
   input  wire logic              rst_n,

   input  wire adder_pkg::addr_t  awaddr,
   input  wire logic              awvalid,
   output logic                   awready,

   input  wire adder_pkg::data_t  wdata,
   input  wire adder_pkg::strb_t  wstrb,
   input  wire logic              wvalid,
   output logic                   wready,

   output adder_pkg::resp_t       bresp,
   output logic                   bvalid,
   input  wire logic              bready,

   input  wire adder_pkg::addr_t  araddr,
   input  wire logic              arvalid,
   output logic                   arready,

   output adder_pkg::data_t       rdata,
   output adder_pkg::resp_t       rresp,
   output logic                   rvalid,
   input  wire logic              rready,

   output logic                   a_we,
   output logic                   b_we,
   output adder_pkg::data_t       wr_data,
   output adder_pkg::strb_t       wr_strb,

   input  wire adder_pkg::data_t  operand_a,
   input  wire adder_pkg::data_t  operand_b,
   input  wire adder_pkg::data_t  sum,
   input  wire logic              carry
);

   localparam adder_pkg::addr_t OFS_A     = adder_pkg::addr_t'(`ADDER_OFS_A);
   localparam adder_pkg::addr_t OFS_B     = adder_pkg::addr_t'(`ADDER_OFS_B);
   localparam adder_pkg::addr_t OFS_SUM   = adder_pkg::addr_t'(`ADDER_OFS_SUM);
   localparam adder_pkg::addr_t OFS_CARRY = adder_pkg::addr_t'(`ADDER_OFS_CARRY);

   adder_pkg::wr_state_t wr_state;
   adder_pkg::rd_state_t rd_state;

   logic             aw_xfer;
   logic             ar_xfer;
   logic             aw_is_a;
   logic             aw_is_b;
   adder_pkg::data_t rd_word;
   adder_pkg::resp_t rd_resp;

   // Ready is only ever raised in IDLE, so a transfer implies IDLE
   assign aw_xfer = awready && wready && awvalid && wvalid;
   assign ar_xfer = arready && arvalid;

   // Only the two operands are writable
   assign aw_is_a = (awaddr == OFS_A);
   assign aw_is_b = (awaddr == OFS_B);

   always_comb
   begin
      rd_resp = adder_pkg::RESP_OKAY;
      case (araddr)
         OFS_A:     rd_word = operand_a;
         OFS_B:     rd_word = operand_b;
         OFS_SUM:   rd_word = sum;
         OFS_CARRY: rd_word = {{(`ADDER_DATA_WIDTH-1){1'b0}}, carry};
         default:
         begin
            rd_word = '0;
            rd_resp = adder_pkg::RESP_SLVERR;
         end
      endcase
   end

   // Write direction FSM
   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         wr_state <= adder_pkg::WR_IDLE;
         awready  <= 1'b0;
         wready   <= 1'b0;
         bvalid   <= 1'b0;
         a_we     <= 1'b0;
         b_we     <= 1'b0;
      end
      else
      begin
         a_we <= 1'b0;
         b_we <= 1'b0;
         case (wr_state)
            adder_pkg::WR_IDLE:
            begin
               if (aw_xfer)
               begin
                  awready  <= 1'b0;
                  wready   <= 1'b0;
                  a_we     <= aw_is_a;
                  b_we     <= aw_is_b;
                  wr_state <= adder_pkg::WR_RESP;
               end
               else if (awvalid && wvalid)
               begin
                  awready <= 1'b1;
                  wready  <= 1'b1;
               end
            end
            adder_pkg::WR_RESP:
            begin
               // bvalid comes up with the operand register update
               if (!bvalid)
                  bvalid <= 1'b1;
               else if (bready)
               begin
                  bvalid   <= 1'b0;
                  wr_state <= adder_pkg::WR_IDLE;
               end
            end
            default: wr_state <= adder_pkg::WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge s1_axi_aclk)
   begin
      if (aw_xfer)
      begin
         wr_data <= wdata;
         wr_strb <= wstrb;
         bresp   <= (aw_is_a || aw_is_b) ? adder_pkg::RESP_OKAY : adder_pkg::RESP_SLVERR;
      end
   end

   // Read direction FSM
   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         rd_state <= adder_pkg::RD_IDLE;
         arready  <= 1'b0;
         rvalid   <= 1'b0;
      end
      else
      begin
         case (rd_state)
            adder_pkg::RD_IDLE:
            begin
               if (ar_xfer)
               begin
                  arready  <= 1'b0;
                  rvalid   <= 1'b1;
                  rd_state <= adder_pkg::RD_DATA;
               end
               else if (arvalid)
                  arready <= 1'b1;
            end
            adder_pkg::RD_DATA:
            begin
               if (rready)
               begin
                  rvalid   <= 1'b0;
                  rd_state <= adder_pkg::RD_IDLE;
               end
            end
            default: rd_state <= adder_pkg::RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge s1_axi_aclk)
   begin
      if (ar_xfer)
      begin
         rdata <= rd_word;
         rresp <= rd_resp;
      end
   end

endmodule

`default_nettype wire

// ==== adder_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "adder_cfg.svh"

module adder_core
(
   input  wire logic             s1_axi_aclk,
   input  wire logic             rst_n,
   input  wire logic             a_we,
   input  wire logic             b_we,
   input  wire adder_pkg::data_t wr_data,
   input  wire adder_pkg::strb_t wr_strb,
   output adder_pkg::data_t      operand_a,
   output adder_pkg::data_t      operand_b,
   output adder_pkg::data_t      sum,
   output logic                  carry
);

   // Byte-wise merge of new data under strobe
   function automatic adder_pkg::data_t merge_bytes(input adder_pkg::data_t old_word,
                                                    input adder_pkg::data_t new_word,
                                                    input adder_pkg::strb_t strb);
      adder_pkg::data_t result;
      result = old_word;
      for (int i = 0; i < `ADDER_DATA_WIDTH/8; i++)
      begin
         if (strb[i])
            result[8*i +: 8] = new_word[8*i +: 8];
      end
      return result;
   endfunction

   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
      begin
         operand_a <= '0;
         operand_b <= '0;
      end
      else
      begin
         if (a_we)
            operand_a <= merge_bytes(operand_a, wr_data, wr_strb);
         if (b_we)
            operand_b <= merge_bytes(operand_b, wr_data, wr_strb);
      end
   end

   // Sum lags the operands by one cycle; carry is the extra top bit
   always_ff @(posedge s1_axi_aclk)
   begin
      if (!rst_n)
         {carry, sum} <= '0;
      else
         {carry, sum} <= {1'b0, operand_a} + {1'b0, operand_b};
   end

endmodule

`default_nettype wire

// ==== adder_pkg.sv ====
`default_nettype none
`include "adder_cfg.svh"

package adder_pkg;

   typedef logic [`ADDER_DATA_WIDTH-1:0]   data_t;
   typedef logic [`ADDER_ADDR_WIDTH-1:0]   addr_t;
   typedef logic [`ADDER_DATA_WIDTH/8-1:0] strb_t;
   typedef logic [1:0]                     resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // One FSM per bus direction
   typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
   typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

// ==== adder_cfg.svh ====
`ifndef ADDER_CFG_SVH
`define ADDER_CFG_SVH

// Bus and operand widths
`define ADDER_DATA_WIDTH 32
`define ADDER_ADDR_WIDTH 8

// Register byte offsets
`define ADDER_OFS_A     0
`define ADDER_OFS_B     4
`define ADDER_OFS_SUM   8
`define ADDER_OFS_CARRY 12

`endif
